/* all.f */
design/tilemap_pkg.sv
design/tile_layer.sv
design/priority_mixer.sv
design/tilemap_mixer_top.sv
verification/tb_tilemap.sv

/* design/priority_mixer.sv */
`timescale 1ns/1ns

module priority_mixer (
	input  logic                           CLK_2H,
	input  logic                           rst,
	input  logic                           cpu_we,
	input  logic [2:0]                     cpu_addr,
	input  logic [tilemap_pkg::ATTR_W-1:0] cpu_data,
	input  logic [tilemap_pkg::PRI_W-1:0]  pri_in,
	input  logic [tilemap_pkg::ATTR_W-1:0] color_in,
	input  logic [tilemap_pkg::PIX_W-1:0]  dot_in,
	input  logic [tilemap_pkg::PIX_W-1:0]  layer_a_dot,
	input  logic [tilemap_pkg::PIX_W-1:0]  layer_b_dot,
	input  logic [tilemap_pkg::ATTR_W-1:0] layer_a_attr,
	input  logic [tilemap_pkg::ATTR_W-1:0] layer_b_attr,
	output logic [tilemap_pkg::PRI_W-1:0]  pri_out,
	output logic [tilemap_pkg::ATTR_W-1:0] color_out,
	output logic [tilemap_pkg::PIX_W-1:0]  dot_out
);
	import tilemap_pkg::*;

	reg_sel_t reg_sel;

	// Current layer priorities
	logic [PRI_W-1:0] pri_a;
	logic [PRI_W-1:0] pri_b;

	// Winner after layer A is considered
	logic [PRI_W-1:0]  mix_a_pri;
	logic [ATTR_W-1:0] mix_a_color;
	logic [PIX_W-1:0]  mix_a_dot;

	// Winner after layer B, goes to the output registers
	logic [PRI_W-1:0]  mix_b_pri;
	logic [ATTR_W-1:0] mix_b_color;
	logic [PIX_W-1:0]  mix_b_dot;

	// Opaque and strictly above what is already there
	function automatic logic takes_over(
		input logic [PIX_W-1:0] cand_dot,
		input logic [PRI_W-1:0] cand_pri,
		input logic [PRI_W-1:0] cur_pri
	);
		takes_over = (cand_dot != TRANSPARENT_PIX) && (cand_pri > cur_pri);
	endfunction

	//////////////////////////////////////////////////
	// CPU priority registers
	//////////////////////////////////////////////////

	always_comb begin
		if (cpu_addr[0]) begin
			reg_sel = SEL_NONE;
		end else if (cpu_addr[2]) begin
			reg_sel = SEL_LAYER_B;
		end else begin
			reg_sel = SEL_LAYER_A;
		end
	end

	// Priority sits in data bits 3..1
	always_ff @(posedge CLK_2H) begin
		if (rst) begin
			pri_a <= LAYER_A_RESET_PRI;
			pri_b <= LAYER_B_RESET_PRI;
		end else if (cpu_we) begin
			case (reg_sel)
				SEL_LAYER_A: pri_a <= cpu_data[3:1];
				SEL_LAYER_B: pri_b <= cpu_data[3:1];
				default: ;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Chain compare
	//////////////////////////////////////////////////

	// Ties keep the earlier source
	always_comb begin
		if (takes_over(layer_a_dot, pri_a, pri_in)) begin
			mix_a_pri   = pri_a;
			mix_a_color = layer_a_attr;
			mix_a_dot   = layer_a_dot;
		end else begin
			mix_a_pri   = pri_in;
			mix_a_color = color_in;
			mix_a_dot   = dot_in;
		end
	end

	always_comb begin
		if (takes_over(layer_b_dot, pri_b, mix_a_pri)) begin
			mix_b_pri   = pri_b;
			mix_b_color = layer_b_attr;
			mix_b_dot   = layer_b_dot;
		end else begin
			mix_b_pri   = mix_a_pri;
			mix_b_color = mix_a_color;
			mix_b_dot   = mix_a_dot;
		end
	end

	// Output stage to the next chip in the chain
	always_ff @(posedge CLK_2H) begin
		if (rst) begin
			pri_out   <= '0;
			color_out <= '0;
			dot_out   <= '0;
		end else begin
			pri_out   <= mix_b_pri;
			color_out <= mix_b_color;
			dot_out   <= mix_b_dot;
		end
	end

endmodule

/* design/tile_layer.sv */
`timescale 1ns/1ns

module tile_layer (
	input  logic                           CLK_2H,
	input  logic                           rst,
	input  logic                           tile_load,
	input  logic                           flip,
	input  logic [tilemap_pkg::ATTR_W-1:0] attr,
	input  logic [tilemap_pkg::GFX_W-1:0]  gfx,
	output logic [tilemap_pkg::PIX_W-1:0]  dot,
	output logic [tilemap_pkg::ATTR_W-1:0] color
);
	import tilemap_pkg::*;

	// Tile attribute, held for the whole segment
	logic [ATTR_W-1:0] attr_q;

	// Incoming planes split out of the packed ROM word
	logic [PLANE_W-1:0] gfx_plane [PIX_W];

	// Plane shift registers and their next values
	logic [PLANE_W-1:0] plane_sr   [PIX_W];
	logic [PLANE_W-1:0] plane_next [PIX_W];

	//////////////////////////////////////////////////
	// Plane unpacking
	//////////////////////////////////////////////////

	always_comb begin
		for (int p = 0; p < PIX_W; p++) begin
			gfx_plane[p] = gfx[p*PLANE_W +: PLANE_W];
		end
	end

	//////////////////////////////////////////////////
	// Shift control
	//////////////////////////////////////////////////

	// Load wins over shift on the tile strobe
	// Normal order drains from bit 3, mirrored order from bit 0
	always_comb begin
		for (int p = 0; p < PIX_W; p++) begin
			if (tile_load) begin
				plane_next[p] = gfx_plane[p];
			end else if (flip) begin
				plane_next[p] = plane_sr[p] >> 1;
			end else begin
				plane_next[p] = plane_sr[p] << 1;
			end
		end
	end

	// Emptied positions fill with 0, so a stale segment reads as code 0
	always_ff @(posedge CLK_2H) begin
		if (rst) begin
			for (int p = 0; p < PIX_W; p++) begin
				plane_sr[p] <= '0;
			end
		end else begin
			for (int p = 0; p < PIX_W; p++) begin
				plane_sr[p] <= plane_next[p];
			end
		end
	end

	//////////////////////////////////////////////////
	// Attribute latch
	//////////////////////////////////////////////////

	always_ff @(posedge CLK_2H) begin
		if (rst) begin
			attr_q <= '0;
		end else if (tile_load) begin
			attr_q <= attr;
		end
	end

	assign color = attr_q;

	//////////////////////////////////////////////////
	// Pixel output
	//////////////////////////////////////////////////

	// One bit per plane from the leading end of each register
	// Plane 0 is the pixel LSB
	always_comb begin
		for (int p = 0; p < PIX_W; p++) begin
			if (flip) begin
				dot[p] = plane_sr[p][0];
			end else begin
				dot[p] = plane_sr[p][PLANE_W-1];
			end
		end
	end

endmodule

/* design/tilemap_mixer_top.sv */
`timescale 1ns/1ns

module tilemap_mixer_top (
	input  logic                           CLK_2H,
	input  logic                           rst,
	input  logic                           tile_load,
	input  logic                           flip,
	input  logic [tilemap_pkg::ATTR_W-1:0] attr_a,
	input  logic [tilemap_pkg::GFX_W-1:0]  gfx_a,
	input  logic [tilemap_pkg::ATTR_W-1:0] attr_b,
	input  logic [tilemap_pkg::GFX_W-1:0]  gfx_b,
	input  logic [tilemap_pkg::PRI_W-1:0]  pri_in,
	input  logic [tilemap_pkg::ATTR_W-1:0] color_in,
	input  logic [tilemap_pkg::PIX_W-1:0]  dot_in,
	input  logic                           cpu_we,
	input  logic [2:0]                     cpu_addr,
	input  logic [tilemap_pkg::ATTR_W-1:0] cpu_data,
	output logic [tilemap_pkg::PRI_W-1:0]  pri_out,
	output logic [tilemap_pkg::ATTR_W-1:0] color_out,
	output logic [tilemap_pkg::PIX_W-1:0]  dot_out
);
	import tilemap_pkg::*;

	// Layer pixels into the mixer
	logic [PIX_W-1:0]  layer_a_dot;
	logic [ATTR_W-1:0] layer_a_attr;
	logic [PIX_W-1:0]  layer_b_dot;
	logic [ATTR_W-1:0] layer_b_attr;

	//////////////////////////////////////////////////
	// Tile layers
	//////////////////////////////////////////////////

	tile_layer i_layer_a (
		.CLK_2H    (CLK_2H),
		.rst       (rst),
		.tile_load (tile_load),
		.flip      (flip),
		.attr      (attr_a),
		.gfx       (gfx_a),
		.dot       (layer_a_dot),
		.color     (layer_a_attr)
	);

	tile_layer i_layer_b (
		.CLK_2H    (CLK_2H),
		.rst       (rst),
		.tile_load (tile_load),
		.flip      (flip),
		.attr      (attr_b),
		.gfx       (gfx_b),
		.dot       (layer_b_dot),
		.color     (layer_b_attr)
	);

	//////////////////////////////////////////////////
	// Priority mix with the chained pixel
	//////////////////////////////////////////////////

	priority_mixer i_mixer (
		.CLK_2H       (CLK_2H),
		.rst          (rst),
		.cpu_we       (cpu_we),
		.cpu_addr     (cpu_addr),
		.cpu_data     (cpu_data),
		.pri_in       (pri_in),
		.color_in     (color_in),
		.dot_in       (dot_in),
		.layer_a_dot  (layer_a_dot),
		.layer_b_dot  (layer_b_dot),
		.layer_a_attr (layer_a_attr),
		.layer_b_attr (layer_b_attr),
		.pri_out      (pri_out),
		.color_out    (color_out),
		.dot_out      (dot_out)
	);

endmodule

/* design/tilemap_pkg.sv */
package tilemap_pkg;

	//////////////////////////////////////////////////
	// Pixel and tile data widths
	//////////////////////////////////////////////////

	// One pixel code, one bit from each plane
	localparam int PIX_W = 3;

	// Colour attribute latched once per tile
	localparam int ATTR_W = 8;

	// Pixels in one tile row segment
	localparam int PLANE_W = 4;

	// Packed planes as they arrive from graphics ROM
	// Plane 0 in 3..0, plane 1 in 7..4, plane 2 in 11..8
	localparam int GFX_W = PIX_W * PLANE_W;

	//////////////////////////////////////////////////
	// Priority and transparency
	//////////////////////////////////////////////////

	localparam int PRI_W = 3;

	// All three planes set means nothing drawn here
	localparam logic [PIX_W-1:0] TRANSPARENT_PIX = 3'd7;

	// Power-up ordering, layer B sits above layer A
	localparam logic [PRI_W-1:0] LAYER_A_RESET_PRI = 3'd1;
	localparam logic [PRI_W-1:0] LAYER_B_RESET_PRI = 3'd2;

	//////////////////////////////////////////////////
	// CPU register select
	//////////////////////////////////////////////////

	// Address bit 0 set means no priority register
	// Otherwise address bit 2 picks the layer
	typedef enum logic [1:0] {
		SEL_LAYER_A,
		SEL_LAYER_B,
		SEL_NONE
	} reg_sel_t;

endpackage

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the tilemap testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log
BIN=obj_dir/tb_tilemap

verilator --binary --timing -f all.f --top-module tb_tilemap -o tb_tilemap

sim_status=0
"./${BIN}" > "${LOG}" 2>&1 || sim_status=$?
cat "${LOG}"

if grep -q "Checks failed" "${LOG}"; then
	echo "Simulation FAILED (exit status ${sim_status})"
	exit 1
fi

if ! grep -q "All checks passed" "${LOG}"; then
	echo "Simulation ended without a result (exit status ${sim_status})"
	exit 1
fi

echo "Simulation PASSED"
exit 0

/* verification/tb_tilemap.sv */
`timescale 1ns/1ns

module tb_tilemap;
	import tilemap_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int MAX_VECTORS  = 64;
	localparam int NUM_FIELDS   = 15;
	localparam INPUT_FILE       = "verification/tilemap_input.txt";

	// Column positions in the input file
	localparam int F_TILE_LOAD = 0;
	localparam int F_FLIP      = 1;
	localparam int F_ATTR_A    = 2;
	localparam int F_GFX_A     = 3;
	localparam int F_ATTR_B    = 4;
	localparam int F_GFX_B     = 5;
	localparam int F_PRI_IN    = 6;
	localparam int F_COLOR_IN  = 7;
	localparam int F_DOT_IN    = 8;
	localparam int F_CPU_WE    = 9;
	localparam int F_CPU_ADDR  = 10;
	localparam int F_CPU_DATA  = 11;
	localparam int F_EXP_PRI   = 12;
	localparam int F_EXP_COLOR = 13;
	localparam int F_EXP_DOT   = 14;

	logic              CLK_2H;
	logic              rst;
	logic              tile_load;
	logic              flip;
	logic [ATTR_W-1:0] attr_a;
	logic [GFX_W-1:0]  gfx_a;
	logic [ATTR_W-1:0] attr_b;
	logic [GFX_W-1:0]  gfx_b;
	logic [PRI_W-1:0]  pri_in;
	logic [ATTR_W-1:0] color_in;
	logic [PIX_W-1:0]  dot_in;
	logic              cpu_we;
	logic [2:0]        cpu_addr;
	logic [ATTR_W-1:0] cpu_data;
	logic [PRI_W-1:0]  pri_out;
	logic [ATTR_W-1:0] color_out;
	logic [PIX_W-1:0]  dot_out;

	// One row per clock cycle with stimulus and expected outputs
	logic [31:0] vectors [MAX_VECTORS][NUM_FIELDS];
	int          num_vectors;
	int          cur_vector;
	int          cycle_count;
	int          cycle_limit;

	tilemap_mixer_top i_tilemap_mixer_top (
		.CLK_2H    (CLK_2H),
		.rst       (rst),
		.tile_load (tile_load),
		.flip      (flip),
		.attr_a    (attr_a),
		.gfx_a     (gfx_a),
		.attr_b    (attr_b),
		.gfx_b     (gfx_b),
		.pri_in    (pri_in),
		.color_in  (color_in),
		.dot_in    (dot_in),
		.cpu_we    (cpu_we),
		.cpu_addr  (cpu_addr),
		.cpu_data  (cpu_data),
		.pri_out   (pri_out),
		.color_out (color_out),
		.dot_out   (dot_out)
	);

	always #2 CLK_2H = ~CLK_2H;

	// Watchdog on total run length
	always @(posedge CLK_2H) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count > cycle_limit) begin
			$display("Checks failed");
			$fatal(1, "Run exceeded %0d cycles without finishing", cycle_limit);
		end
	end

	//////////////////////////////////////////////////
	// Helpers
	//////////////////////////////////////////////////

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			$display("CHECK FAILED time=%0t vector=%0d signal=%s expected=0x%0h actual=0x%0h",
				$time, cur_vector, name, expected, actual);
			$display("Checks failed");
			$fatal(1, "Output mismatch");
		end
	endtask

	task automatic load_vectors();
		int          fd;
		int          rc;
		int          count;
		string       line;
		logic [31:0] f [NUM_FIELDS];
		fd = $fopen(INPUT_FILE, "r");
		if (fd == 0) begin
			$display("Checks failed");
			$fatal(1, "Could not open the stimulus file %s", INPUT_FILE);
		end
		num_vectors = 0;
		while (!$feof(fd)) begin
			line = "";
			rc = $fgets(line, fd);
			// Skip comment and blank lines
			if (rc == 0 || line.len() < 2 || line.getc(0) == "#") begin
				continue;
			end
			count = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
				f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7],
				f[8], f[9], f[10], f[11], f[12], f[13], f[14]);
			if (count != NUM_FIELDS) begin
				$display("Checks failed");
				$fatal(1, "Stimulus line %0d has %0d fields, %0d needed",
					num_vectors, count, NUM_FIELDS);
			end
			if (num_vectors >= MAX_VECTORS) begin
				$display("Checks failed");
				$fatal(1, "Stimulus file holds more than %0d vectors", MAX_VECTORS);
			end
			for (int i = 0; i < NUM_FIELDS; i++) begin
				vectors[num_vectors][i] = f[i];
			end
			num_vectors++;
		end
		$fclose(fd);
	endtask

	task automatic drive_vector(input int idx);
		tile_load = vectors[idx][F_TILE_LOAD][0];
		flip      = vectors[idx][F_FLIP][0];
		attr_a    = vectors[idx][F_ATTR_A][ATTR_W-1:0];
		gfx_a     = vectors[idx][F_GFX_A][GFX_W-1:0];
		attr_b    = vectors[idx][F_ATTR_B][ATTR_W-1:0];
		gfx_b     = vectors[idx][F_GFX_B][GFX_W-1:0];
		pri_in    = vectors[idx][F_PRI_IN][PRI_W-1:0];
		color_in  = vectors[idx][F_COLOR_IN][ATTR_W-1:0];
		dot_in    = vectors[idx][F_DOT_IN][PIX_W-1:0];
		cpu_we    = vectors[idx][F_CPU_WE][0];
		cpu_addr  = vectors[idx][F_CPU_ADDR][2:0];
		cpu_data  = vectors[idx][F_CPU_DATA][ATTR_W-1:0];
	endtask

	task automatic check_outputs(input int idx);
		cur_vector = idx;
		check_value("pri_out", vectors[idx][F_EXP_PRI], 32'(pri_out));
		check_value("color_out", vectors[idx][F_EXP_COLOR], 32'(color_out));
		check_value("dot_out", vectors[idx][F_EXP_DOT], 32'(dot_out));
	endtask

	//////////////////////////////////////////////////
	// Main sequence
	//////////////////////////////////////////////////

	initial begin
		CLK_2H        = 1'b0;
		rst           = 1'b1;
		tile_load     = 1'b0;
		flip          = 1'b0;
		attr_a        = '0;
		gfx_a         = '0;
		attr_b        = '0;
		gfx_b         = '0;
		pri_in        = '0;
		color_in      = '0;
		dot_in        = '0;
		cpu_we        = 1'b0;
		cpu_addr      = '0;
		cpu_data      = '0;
		cur_vector    = 0;
		cycle_count   = 0;
		cycle_limit   = RESET_CYCLES + 20;

		load_vectors();
		cycle_limit = num_vectors + RESET_CYCLES + 20;

		repeat (RESET_CYCLES) @(posedge CLK_2H);
		#1;

		// Output registers clear while reset is held
		check_value("pri_out", 32'd0, 32'(pri_out));
		check_value("color_out", 32'd0, 32'(color_out));
		check_value("dot_out", 32'd0, 32'(dot_out));
		rst = 1'b0;

		// Inputs go in 1 ns after an edge and outputs are checked 1 ns after the next one
		for (int idx = 0; idx < num_vectors; idx++) begin
			drive_vector(idx);
			@(posedge CLK_2H);
			#1;
			check_outputs(idx);
		end

		if (num_vectors > 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			$display("Checks failed");
			$fatal(1, "The stimulus file holds no vectors");
		end
	end

endmodule

/* verification/tilemap_input.txt */
# tile_load flip attr_a gfx_a attr_b gfx_b pri_in color_in dot_in cpu_we cpu_addr cpu_data
#   then expected pri_out color_out dot_out, all hex, one line per clock
1 0 a1 f0f b1 16a 0 c0 3 0 0 00 2 00 0
0 0 00 000 00 000 0 c0 3 0 0 00 2 b1 1
0 0 00 000 00 000 0 c0 3 0 0 00 2 b1 2
0 0 00 000 00 000 0 c0 3 0 0 00 2 b1 3
1 0 a1 f0f b2 16a 0 c0 3 0 0 00 2 b1 4
0 1 00 000 00 000 0 c0 3 0 0 00 2 b2 4
0 1 00 000 00 000 0 c0 3 0 0 00 2 b2 3
0 1 00 000 00 000 0 c0 3 0 0 00 2 b2 2
1 1 a2 57d b3 fff 0 c0 3 0 0 00 2 b2 1
0 0 00 000 00 000 0 c0 3 0 0 00 1 a2 1
0 0 00 000 00 000 0 c1 6 0 0 00 0 c1 6
0 0 00 000 00 000 0 c0 3 0 0 00 1 a2 2
1 0 a3 f0f b4 16a 0 c1 6 0 0 00 0 c1 6
0 0 00 000 00 000 3 c3 6 0 0 00 3 c3 6
0 0 00 000 00 000 3 c3 6 0 0 00 3 c3 6
0 0 00 000 00 000 3 c3 6 1 5 0e 3 c3 6
1 0 a5 16a b5 16a 3 c3 6 1 0 0a 3 c3 6
0 0 00 000 00 000 3 c3 6 0 0 00 5 a5 1
0 0 00 000 00 000 3 c3 6 1 4 0a 5 a5 2
0 0 00 000 00 000 3 c3 6 0 0 00 5 a5 3
1 0 a6 16a b6 f0f 3 c3 6 0 0 00 5 a5 4
0 0 00 000 00 000 5 c5 2 0 0 00 5 c5 2
0 0 00 000 00 000 4 c4 6 0 0 00 5 a6 2
0 0 00 000 00 000 5 c5 2 0 0 00 5 c5 2
0 0 00 000 00 000 0 c0 3 0 0 00 5 a6 4
0 0 00 000 00 000 0 c0 3 0 0 00 5 a6 0
